// File: hdl/letter_decoder.sv
`include "wordnum_config.svh"

module letter_decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 char_valid,
  input  wordnum_pkg::char_t   char_in,
  output logic                 letter_valid,
  output wordnum_pkg::letter_e letter
);
  import wordnum_pkg::*;

  localparam char_t line_end = char_t'(`WORDNUM_LINE_END);

  letter_e code;

  // capitals and numerals fall into other
  always_comb begin
    case (char_in)
      "e":      code = lc_e;
      "f":      code = lc_f;
      "g":      code = lc_g;
      "h":      code = lc_h;
      "i":      code = lc_i;
      "n":      code = lc_n;
      "o":      code = lc_o;
      "r":      code = lc_r;
      "s":      code = lc_s;
      "t":      code = lc_t;
      "u":      code = lc_u;
      "v":      code = lc_v;
      "w":      code = lc_w;
      "x":      code = lc_x;
      line_end: code = lc_eol;
      default:  code = lc_other;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      letter_valid <= 1'b0;
    end else begin
      letter_valid <= char_valid;
    end
  end

  // code of the accepted character
  always_ff @(posedge clk) begin
    if (char_valid) begin
      letter <= code;
    end
  end

endmodule

// File: hdl/line_digit_collector.sv
module line_digit_collector (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     match_valid,
  input  wordnum_pkg::digit_t      match_digit,
  input  logic                     eol_valid,
  output logic                     digit_valid,
  output wordnum_pkg::digit_t      digit_value,
  output logic                     line_valid,
  output logic                     line_has_digit,
  output wordnum_pkg::line_value_t line_value
);
  import wordnum_pkg::*;

  digit_t      first_digit;
  digit_t      last_digit;
  logic        seen;
  line_value_t line_sum;

  // first digit is tens, last is units
  assign line_sum = line_value_t'(first_digit) * line_value_t'(10)
                  + line_value_t'(last_digit);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      digit_valid <= 1'b0;
      line_valid  <= 1'b0;
      seen        <= 1'b0;
    end else begin
      digit_valid <= match_valid;
      line_valid  <= eol_valid;
      // a line end starts a fresh line
      if (eol_valid) begin
        seen <= 1'b0;
      end else if (match_valid) begin
        seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (match_valid) begin
      digit_value <= match_digit;
      last_digit  <= match_digit;
      if (!seen) begin
        first_digit <= match_digit;
      end
    end
    if (eol_valid) begin
      line_has_digit <= seen;
      // empty line reports zero
      line_value     <= seen ? line_sum : '0;
    end
  end

endmodule

// File: hdl/spelled_digit_top.sv
module spelled_digit_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     char_valid,
  input  wordnum_pkg::char_t       char_in,
  output logic                     digit_valid,
  output wordnum_pkg::digit_t      digit_value,
  output logic                     line_valid,
  output logic                     line_has_digit,
  output wordnum_pkg::line_value_t line_value
);
  import wordnum_pkg::*;

  logic    letter_valid;
  letter_e letter;
  logic    match_valid;
  digit_t  match_digit;
  logic    eol_valid;

  // character to letter code
  letter_decoder letter_decoder_inst (
    .clk          (clk),
    .rst          (rst),
    .char_valid   (char_valid),
    .char_in      (char_in),
    .letter_valid (letter_valid),
    .letter       (letter)
  );

  word_matcher word_matcher_inst (
    .clk          (clk),
    .rst          (rst),
    .letter_valid (letter_valid),
    .letter       (letter),
    .match_valid  (match_valid),
    .match_digit  (match_digit),
    .eol_valid    (eol_valid)
  );

  // digit pulses and per-line value
  line_digit_collector line_digit_collector_inst (
    .clk            (clk),
    .rst            (rst),
    .match_valid    (match_valid),
    .match_digit    (match_digit),
    .eol_valid      (eol_valid),
    .digit_valid    (digit_valid),
    .digit_value    (digit_value),
    .line_valid     (line_valid),
    .line_has_digit (line_has_digit),
    .line_value     (line_value)
  );

endmodule

// File: hdl/word_matcher.sv
module word_matcher (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 letter_valid,
  input  wordnum_pkg::letter_e letter,
  output logic                 match_valid,
  output wordnum_pkg::digit_t  match_digit,
  output logic                 eol_valid
);
  import wordnum_pkg::*;

  match_state_e state;
  match_state_e state_next;
  digit_t       digit_next;

  // a complete word continues as its longest suffix that is a prefix
  function automatic match_state_e settle(match_state_e cur);
    case (cur)
      ms_one, ms_three, ms_five, ms_nine: return ms_e;
      ms_two:                             return ms_o;
      ms_seven:                           return ms_n;
      ms_eight:                           return ms_t;
      ms_four, ms_six:                    return ms_idle;
      default:                            return cur;
    endcase
  endfunction

  // letters that can open a word on their own
  function automatic match_state_e restart(letter_e l);
    case (l)
      lc_o:    return ms_o;
      lc_t:    return ms_t;
      lc_f:    return ms_f;
      lc_s:    return ms_s;
      lc_e:    return ms_e;
      lc_n:    return ms_n;
      default: return ms_idle;
    endcase
  endfunction

  function automatic match_state_e step(match_state_e cur, letter_e l);
    match_state_e base;
    match_state_e nxt;
    base = settle(cur);
    // fallback when the word in progress does not continue
    nxt = restart(l);
    case (base)
      ms_o:    if (l == lc_n) nxt = ms_on;
      ms_on: begin
        if (l == lc_e) nxt = ms_one;
        // "oni" keeps "ni"
        else if (l == lc_i) nxt = ms_ni;
      end
      ms_t: begin
        if (l == lc_w) nxt = ms_tw;
        else if (l == lc_h) nxt = ms_th;
      end
      ms_tw:   if (l == lc_o) nxt = ms_two;
      ms_th:   if (l == lc_r) nxt = ms_thr;
      ms_thr:  if (l == lc_e) nxt = ms_thre;
      ms_thre: begin
        if (l == lc_e) nxt = ms_three;
        else if (l == lc_i) nxt = ms_ei;
      end
      ms_f: begin
        if (l == lc_o) nxt = ms_fo;
        else if (l == lc_i) nxt = ms_fi;
      end
      ms_fo: begin
        if (l == lc_u) nxt = ms_fou;
        // "fon" keeps "on"
        else if (l == lc_n) nxt = ms_on;
      end
      ms_fou:  if (l == lc_r) nxt = ms_four;
      ms_fi:   if (l == lc_v) nxt = ms_fiv;
      ms_fiv:  if (l == lc_e) nxt = ms_five;
      ms_s: begin
        if (l == lc_i) nxt = ms_si;
        else if (l == lc_e) nxt = ms_se;
      end
      ms_si:   if (l == lc_x) nxt = ms_six;
      ms_se: begin
        if (l == lc_v) nxt = ms_sev;
        else if (l == lc_i) nxt = ms_ei;
      end
      ms_sev:  if (l == lc_e) nxt = ms_seve;
      ms_seve: begin
        if (l == lc_n) nxt = ms_seven;
        else if (l == lc_i) nxt = ms_ei;
      end
      ms_e:    if (l == lc_i) nxt = ms_ei;
      ms_ei:   if (l == lc_g) nxt = ms_eig;
      ms_eig:  if (l == lc_h) nxt = ms_eigh;
      ms_eigh: if (l == lc_t) nxt = ms_eight;
      ms_n:    if (l == lc_i) nxt = ms_ni;
      ms_ni:   if (l == lc_n) nxt = ms_nin;
      ms_nin: begin
        if (l == lc_e) nxt = ms_nine;
        // "nini" keeps "ni"
        else if (l == lc_i) nxt = ms_ni;
      end
      default: ;
    endcase
    return nxt;
  endfunction

  // zero for anything that is not a complete word
  function automatic digit_t word_digit(match_state_e s);
    case (s)
      ms_one:   return digit_t'(1);
      ms_two:   return digit_t'(2);
      ms_three: return digit_t'(3);
      ms_four:  return digit_t'(4);
      ms_five:  return digit_t'(5);
      ms_six:   return digit_t'(6);
      ms_seven: return digit_t'(7);
      ms_eight: return digit_t'(8);
      ms_nine:  return digit_t'(9);
      default:  return digit_t'(0);
    endcase
  endfunction

  // other and line end fall through to idle
  assign state_next = step(state, letter);
  assign digit_next = word_digit(state_next);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state       <= ms_idle;
      match_valid <= 1'b0;
      eol_valid   <= 1'b0;
    end else begin
      match_valid <= 1'b0;
      eol_valid   <= 1'b0;
      if (letter_valid) begin
        state       <= state_next;
        match_valid <= (digit_next != '0);
        eol_valid   <= (letter == lc_eol);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (letter_valid && digit_next != '0) begin
      match_digit <= digit_next;
    end
  end

endmodule

// File: hdl/wordnum_config.svh
`ifndef WORDNUM_CONFIG_SVH
`define WORDNUM_CONFIG_SVH

// input character and digit widths
`define WORDNUM_CHAR_W 8
`define WORDNUM_DIGIT_W 4
// wide enough for 99
`define WORDNUM_LINE_VALUE_W 7

// ascii line feed closes a line
`define WORDNUM_LINE_END 10

`endif

// File: hdl/wordnum_pkg.sv
`include "wordnum_config.svh"

package wordnum_pkg;

  typedef logic [`WORDNUM_CHAR_W-1:0]       char_t;
  typedef logic [`WORDNUM_DIGIT_W-1:0]      digit_t;
  typedef logic [`WORDNUM_LINE_VALUE_W-1:0] line_value_t;

  // only letters that occur in "one" .. "nine" get their own code
  typedef enum logic [3:0] {
    lc_e, lc_f, lc_g, lc_h, lc_i, lc_n, lc_o,
    lc_r, lc_s, lc_t, lc_u, lc_v, lc_w, lc_x,
    // anything else breaks a word
    lc_other,
    lc_eol
  } letter_e;

  // last prefix of each row is the complete word
  typedef enum logic [5:0] {
    ms_idle,
    ms_o, ms_on, ms_one,
    ms_t, ms_tw, ms_two,
    ms_th, ms_thr, ms_thre, ms_three,
    ms_f, ms_fo, ms_fou, ms_four,
    ms_fi, ms_fiv, ms_five,
    ms_s, ms_si, ms_six,
    ms_se, ms_sev, ms_seve, ms_seven,
    ms_e, ms_ei, ms_eig, ms_eigh, ms_eight,
    ms_n, ms_ni, ms_nin, ms_nine
  } match_state_e;

endpackage

// File: sim.f
+incdir+hdl
hdl/wordnum_pkg.sv
hdl/letter_decoder.sv
hdl/word_matcher.sv
hdl/line_digit_collector.sv
hdl/spelled_digit_top.sv
test/clock_reset_gen.sv
test/spelled_digit_checker.sv
test/spelled_digit_tb.sv

// File: test/clock_reset_gen.sv
module clock_reset_gen (
  output logic clk,
  output logic rst
);

  // period of 10
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset low for the first 10 rising edges
  initial begin
    rst = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
  end

endmodule

// File: test/spelled_digit_checker.sv
module spelled_digit_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              cycle,
  input  logic                     digit_valid,
  input  wordnum_pkg::digit_t      digit_value,
  input  logic                     line_valid,
  input  logic                     line_has_digit,
  input  wordnum_pkg::line_value_t line_value
);
  import wordnum_pkg::*;

  // expected values with the cycle count they should show up on
  digit_t      digit_q[$];
  int          digit_cyc_q[$];
  logic        has_q[$];
  line_value_t value_q[$];
  int          line_cyc_q[$];

  int value_errors    = 0;
  int timing_errors   = 0;
  int protocol_errors = 0;

  task automatic expect_digit(digit_t d, int cyc);
    digit_q.push_back(d);
    digit_cyc_q.push_back(cyc);
  endtask

  task automatic expect_line(logic has, line_value_t v, int cyc);
    has_q.push_back(has);
    value_q.push_back(v);
    line_cyc_q.push_back(cyc);
  endtask

  function automatic int pending();
    return digit_q.size() + has_q.size();
  endfunction

  task automatic report_leftovers();
    if (digit_q.size() > 0) begin
      $display("error: %0d expected digits never arrived", digit_q.size());
      protocol_errors++;
    end
    if (has_q.size() > 0) begin
      $display("error: %0d expected line results never arrived", has_q.size());
      protocol_errors++;
    end
  endtask

  task automatic check_time(string what, int want);
    if (cycle != want) begin
      $display("error: %s pulse came at cycle %0d instead of cycle %0d", what, cycle, want);
      timing_errors++;
    end
  endtask

  task automatic check_digit();
    digit_t want;
    if (digit_q.size() == 0) begin
      $display("error: digit pulse at time %0t with no digit expected", $time);
      protocol_errors++;
    end else begin
      want = digit_q.pop_front();
      check_time("digit", digit_cyc_q.pop_front());
      if (digit_value !== want) begin
        $display("FAILED at time %0t: digit_value expected %0d, got %0d",
                 $time, want, digit_value);
        value_errors++;
      end
    end
  endtask

  task automatic check_line();
    logic        want_has;
    line_value_t want_value;
    if (has_q.size() == 0) begin
      $display("error: line pulse at time %0t with no line expected", $time);
      protocol_errors++;
    end else begin
      want_has   = has_q.pop_front();
      want_value = value_q.pop_front();
      check_time("line", line_cyc_q.pop_front());
      if (line_has_digit !== want_has) begin
        $display("FAILED at time %0t: line_has_digit expected %0b, got %0b",
                 $time, want_has, line_has_digit);
        value_errors++;
      end
      if (line_value !== want_value) begin
        $display("FAILED at time %0t: line_value expected %0d, got %0d",
                 $time, want_value, line_value);
        value_errors++;
      end
    end
  endtask

  // sampled half a period after the outputs change
  always @(negedge clk) begin
    if (rst) begin
      if (digit_valid) begin
        check_digit();
      end
      if (line_valid) begin
        check_line();
      end
    end
  end

endmodule

// File: test/spelled_digit_tb.sv
`include "wordnum_config.svh"

module spelled_digit_tb;
  import wordnum_pkg::*;

  localparam int entries = 20;

  logic        clk;
  logic        rst;
  logic        char_valid;
  char_t       char_in;
  logic        digit_valid;
  digit_t      digit_value;
  logic        line_valid;
  logic        line_has_digit;
  line_value_t line_value;

  // mask holds the digit under the letter that ends a word
  string text_tab [entries];
  string mask_tab [entries];
  logic  has_tab [entries];
  int    value_tab [entries];
  int    n_entries = 0;
  int    seed;
  int    cycle = 0;
  int    limit = 0;
  int    timeouts = 0;

  clock_reset_gen clock_reset_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  spelled_digit_top spelled_digit_top_inst (
    .clk            (clk),
    .rst            (rst),
    .char_valid     (char_valid),
    .char_in        (char_in),
    .digit_valid    (digit_valid),
    .digit_value    (digit_value),
    .line_valid     (line_valid),
    .line_has_digit (line_has_digit),
    .line_value     (line_value)
  );

  spelled_digit_checker checker_inst (
    .clk            (clk),
    .rst            (rst),
    .cycle          (cycle),
    .digit_valid    (digit_valid),
    .digit_value    (digit_value),
    .line_valid     (line_valid),
    .line_has_digit (line_has_digit),
    .line_value     (line_value)
  );

  task automatic add_entry(string text, string mask, logic has, int value);
    text_tab[n_entries]  = text;
    mask_tab[n_entries]  = mask;
    has_tab[n_entries]   = has;
    value_tab[n_entries] = value;
    n_entries++;
  endtask

  task automatic load_table();
    add_entry("one", "..1", 1'b1, 11);
    add_entry("two", "..2", 1'b1, 22);
    add_entry("three", "....3", 1'b1, 33);
    add_entry("four", "...4", 1'b1, 44);
    add_entry("five", "...5", 1'b1, 55);
    add_entry("six", "..6", 1'b1, 66);
    add_entry("seven", "....7", 1'b1, 77);
    add_entry("eight", "....8", 1'b1, 88);
    add_entry("nine", "...9", 1'b1, 99);
    // overlapping words
    add_entry("eightwothree", "....8.2....3", 1'b1, 83);
    add_entry("twone", "..2.1", 1'b1, 21);
    add_entry("sevenine", "....7..9", 1'b1, 79);
    add_entry("oneight", "..1...8", 1'b1, 18);
    // false starts
    add_entry("ffour", "....4", 1'b1, 44);
    add_entry("fone", "...1", 1'b1, 11);
    add_entry("ninine", ".....9", 1'b1, 99);
    add_entry("thrthree", ".......3", 1'b1, 33);
    // space, capitals and numerals break words
    add_entry("fi ve", ".....", 1'b0, 0);
    add_entry("FIVE", "....", 1'b0, 0);
    add_entry("5x", "..", 1'b0, 0);
  endtask

  // one character then 0 to 3 idle cycles
  task automatic send_char(char_t c);
    int gap;
    gap = $unsigned($random(seed)) % 4;
    char_valid = 1'b1;
    char_in    = c;
    @(posedge clk);
    #1;
    char_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_entry(int i);
    byte c;
    for (int k = 0; k < text_tab[i].len(); k++) begin
      c = text_tab[i][k];
      // sampled at the next edge and out two edges later
      if (mask_tab[i][k] != ".") begin
        checker_inst.expect_digit(digit_t'(mask_tab[i][k] - "0"), cycle + 3);
      end
      send_char(char_t'(c));
    end
    checker_inst.expect_line(has_tab[i], line_value_t'(value_tab[i]), cycle + 3);
    send_char(char_t'(`WORDNUM_LINE_END));
  endtask

  task automatic finish_run();
    int total;
    checker_inst.report_leftovers();
    total = checker_inst.value_errors + checker_inst.timing_errors
          + checker_inst.protocol_errors + timeouts;
    $display("errors: value %0d, timing %0d, protocol %0d, timeout %0d",
             checker_inst.value_errors, checker_inst.timing_errors,
             checker_inst.protocol_errors, timeouts);
    if (total == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= limit) begin
      $display("error: run did not finish within %0d cycles", limit);
      timeouts = 1;
      finish_run();
    end
  end

  initial begin
    int total_chars;
    char_valid  = 1'b0;
    char_in     = '0;
    seed        = 22936;
    total_chars = 0;
    load_table();
    // at most 4 cycles per character and per line feed
    for (int i = 0; i < n_entries; i++) begin
      total_chars += text_tab[i].len() + 1;
    end
    limit = 4 * total_chars + 50;
    wait (rst === 1'b1);
    @(posedge clk);
    #1;
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    while (checker_inst.pending() > 0) begin
      @(posedge clk);
    end
    // catch any late stray pulse
    repeat (5) @(posedge clk);
    finish_run();
  end

endmodule
